// File: source/div_sqrt_defs.svh
`ifndef DIV_SQRT_DEFS_SVH
`define DIV_SQRT_DEFS_SVH

// Datapath widths, everything is carried in FP64 alignment
`define DSQ_OP_W    64
`define DSQ_EXP_W   12
`define DSQ_MANT_W  53
`define DSQ_QUOT_W  55

`define DSQ_ITERS   55
`define DSQ_CNT_W   6 // Holds DSQ_ITERS + 1

// Exponent bias per format
`define DSQ_BIAS_FP32    127
`define DSQ_BIAS_FP64    1023
`define DSQ_BIAS_FP16    15
`define DSQ_BIAS_FP16ALT 127

`endif

// File: source/div_sqrt_pkg.sv
`include "div_sqrt_defs.svh"

package div_sqrt_pkg;

	typedef logic [`DSQ_OP_W-1:0]          operand_t;
	typedef logic [`DSQ_EXP_W-1:0]         exp_t;   // Below one for subnormals, read signed
	typedef logic signed [`DSQ_EXP_W:0]    exp_z_t;
	typedef logic [`DSQ_MANT_W-1:0]        mant_t;
	typedef logic [`DSQ_QUOT_W-1:0]        quot_t;

	typedef enum logic [1:0] {
		FMT_FP32    = 2'd0,
		FMT_FP64    = 2'd1,
		FMT_FP16    = 2'd2,
		FMT_FP16ALT = 2'd3
	} fmt_t;

	typedef enum logic [1:0] {
		CLS_NORMAL = 2'd0,
		CLS_ZERO   = 2'd1,
		CLS_INF    = 2'd2,
		CLS_QNAN   = 2'd3
	} res_class_t;

	typedef struct packed {
		logic  sign;
		exp_t  exp;
		mant_t mant;
		logic  zero;
		logic  inf;
		logic  nan;
		logic  snan;
	} op_info_t;

	typedef struct packed {
		logic       sign;
		res_class_t cls;
		exp_z_t     exp;
		quot_t      quot;
		logic       invalid;
		logic       div_by_zero;
	} result_t;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_ITER,
		ST_DONE
	} ctrl_state_t;

endpackage

// File: source/lzc.sv
`timescale 1ns/10ps

module lzc #(
	parameter int WIDTH = 53,
	localparam int CNT_W = $clog2(WIDTH)
) (
	input  logic [WIDTH-1:0] in,
	output logic [CNT_W-1:0] cnt,
	output logic             empty
);

	// Scan upward so the highest set bit decides the count
	always_comb begin
		cnt = '0;
		for (int i = 0; i < WIDTH; i++) begin
			if (in[i]) begin
				cnt = CNT_W'(WIDTH - 1 - i);
			end
		end
	end

	assign empty = ~|in;

endmodule

// File: source/preprocess.sv
`timescale 1ns/10ps
`include "div_sqrt_defs.svh"

module preprocess (
	input  logic                   Clk_CI,
	input  logic                   Rst_RBI,
	input  logic                   div_start,
	input  logic                   sqrt_start,
	input  logic                   ready,
	input  div_sqrt_pkg::operand_t op_a,
	input  div_sqrt_pkg::operand_t op_b,
	input  div_sqrt_pkg::fmt_t     fmt,
	output logic                   accepted,
	output div_sqrt_pkg::op_info_t info_a,
	output div_sqrt_pkg::op_info_t info_b,
	output logic                   sign_z,
	output logic                   is_sqrt,
	output logic                   exp_odd,
	output div_sqrt_pkg::exp_t     fmt_bias
);
	import div_sqrt_pkg::*;

	localparam int CNT_W = $clog2(`DSQ_MANT_W);

	op_info_t         raw_a;
	op_info_t         raw_b;
	op_info_t         norm_a;
	op_info_t         norm_b;
	logic [CNT_W-1:0] lz_a;
	logic [CNT_W-1:0] lz_b;
	logic             empty_a;
	logic             empty_b;
	exp_t             bias_d;
	exp_t             exp_unb;

	// Fraction is left aligned to the FP64 field, so the quiet bit is always bit 51
	function automatic op_info_t unpack_op(operand_t op, fmt_t f);
		op_info_t    u;
		logic [10:0] e;
		logic [51:0] m;
		logic        e_max;
		u = '0;
		case (f)
			FMT_FP32: begin
				u.sign = op[31];
				e      = {3'b000, op[30:23]};
				m      = {op[22:0], 29'b0};
				e_max  = &op[30:23];
			end
			FMT_FP64: begin
				u.sign = op[63];
				e      = op[62:52];
				m      = op[51:0];
				e_max  = &op[62:52];
			end
			FMT_FP16: begin
				u.sign = op[15];
				e      = {6'b000000, op[14:10]};
				m      = {op[9:0], 42'b0};
				e_max  = &op[14:10];
			end
			FMT_FP16ALT: begin
				u.sign = op[15];
				e      = {3'b000, op[14:7]};
				m      = {op[6:0], 45'b0};
				e_max  = &op[14:7];
			end
		endcase
		u.exp  = {1'b0, e};
		u.mant = {|e, m}; // Hidden bit
		u.inf  = e_max & ~|m;
		u.nan  = e_max & |m;
		u.snan = u.nan & ~m[51];
		return u;
	endfunction

	assign accepted = ready & (div_start | sqrt_start);

	assign raw_a = unpack_op(op_a, fmt);
	assign raw_b = unpack_op(op_b, fmt);

	lzc #(
		.WIDTH(`DSQ_MANT_W)
	) lzc_a (
		.in    (raw_a.mant),
		.cnt   (lz_a),
		.empty (empty_a)
	);

	lzc #(
		.WIDTH(`DSQ_MANT_W)
	) lzc_b (
		.in    (raw_b.mant),
		.cnt   (lz_b),
		.empty (empty_b)
	);

	always_comb begin
		norm_a      = raw_a;
		norm_a.zero = empty_a;
		norm_a.mant = raw_a.mant << lz_a;
		norm_a.exp  = raw_a.exp - exp_t'(lz_a) + exp_t'(|lz_a); // Subnormal exp is 1, not 0
		norm_b      = raw_b;
		norm_b.zero = empty_b;
		norm_b.mant = raw_b.mant << lz_b;
		norm_b.exp  = raw_b.exp - exp_t'(lz_b) + exp_t'(|lz_b);
	end

	always_comb begin
		case (fmt)
			FMT_FP32:    bias_d = exp_t'(`DSQ_BIAS_FP32);
			FMT_FP64:    bias_d = exp_t'(`DSQ_BIAS_FP64);
			FMT_FP16:    bias_d = exp_t'(`DSQ_BIAS_FP16);
			FMT_FP16ALT: bias_d = exp_t'(`DSQ_BIAS_FP16ALT);
		endcase
	end

	assign exp_unb = norm_a.exp - bias_d;

	always_ff @(posedge Clk_CI or negedge Rst_RBI) begin
		if (!Rst_RBI) begin
			is_sqrt <= 1'b0;
			sign_z  <= 1'b0;
		end else if (accepted) begin
			is_sqrt <= ~div_start; // Division wins
			sign_z  <= div_start ? (raw_a.sign ^ raw_b.sign) : raw_a.sign;
		end
	end

	always_ff @(posedge Clk_CI) begin
		if (accepted) begin
			info_a   <= norm_a;
			info_b   <= norm_b;
			fmt_bias <= bias_d;
			exp_odd  <= exp_unb[0];
		end
	end

	norm_mant: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
		accepted |=> ((info_a.zero || info_a.inf || info_a.nan || info_a.mant[`DSQ_MANT_W-1]) &&
		              (info_b.zero || info_b.inf || info_b.nan || info_b.mant[`DSQ_MANT_W-1])))
		else $error("registered mantissa not normalized");

endmodule

// File: source/iteration_unit.sv
`timescale 1ns/10ps
`include "div_sqrt_defs.svh"

module iteration_unit (
	input  logic                Clk_CI,
	input  logic                Rst_RBI,
	input  logic                iter_load,
	input  logic                is_sqrt,
	input  logic                exp_odd,
	input  div_sqrt_pkg::mant_t mant_a,
	input  div_sqrt_pkg::mant_t mant_b,
	output div_sqrt_pkg::quot_t quot
);
	import div_sqrt_pkg::*;

	localparam int REM_W = `DSQ_QUOT_W + 3; // Room for root remainder plus two new bits
	localparam int RAD_W = `DSQ_MANT_W + 1;

	logic [REM_W-1:0]      rem_q;
	logic [REM_W-1:0]      rem_cur;
	logic [REM_W-1:0]      trial;
	logic [REM_W-1:0]      diff;
	logic [REM_W-1:0]      rem_next;
	logic [RAD_W-1:0]      rad_q;
	logic [`DSQ_CNT_W-1:0] steps_q;
	logic                  pend_q;
	logic                  run;
	logic                  fit;
	quot_t                 work_q;

	assign run = (steps_q != '0);

	always_comb begin
		if (is_sqrt) begin
			rem_cur = {rem_q[REM_W-3:0], rad_q[RAD_W-1 -: 2]}; // Next radicand pair
			trial   = {1'b0, work_q, 2'b01};                   // 4q + 1
		end else begin
			rem_cur = rem_q;
			trial   = REM_W'(mant_b);
		end
		fit      = (rem_cur >= trial);
		diff     = fit ? rem_cur - trial : rem_cur;
		rem_next = is_sqrt ? diff : {diff[REM_W-2:0], 1'b0};
	end

	always_ff @(posedge Clk_CI or negedge Rst_RBI) begin
		if (!Rst_RBI) begin
			steps_q <= '0;
			pend_q  <= 1'b0;
		end else if (iter_load) begin
			steps_q <= `DSQ_CNT_W'(`DSQ_ITERS);
			pend_q  <= 1'b1;
		end else if (run) begin
			steps_q <= steps_q - 1'b1;
		end else begin
			pend_q <= 1'b0;
		end
	end

	always_ff @(posedge Clk_CI) begin
		if (iter_load) begin
			rem_q  <= is_sqrt ? '0 : REM_W'(mant_a);
			rad_q  <= exp_odd ? {mant_a, 1'b0} : {1'b0, mant_a}; // Odd exponent doubles radicand
			work_q <= '0;
		end else if (run) begin
			rem_q  <= rem_next;
			rad_q  <= {rad_q[RAD_W-3:0], 2'b00};
			work_q <= {work_q[`DSQ_QUOT_W-2:0], fit};
		end
		if (pend_q && !run) begin
			quot <= work_q; // Publish together with done
		end
	end

	rem_bound: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
		(run && !is_sqrt) |-> (rem_q < {mant_b, 1'b0}))
		else $error("division remainder not below twice the divisor");

endmodule

// File: source/div_sqrt_ctrl.sv
`timescale 1ns/10ps
`include "div_sqrt_defs.svh"

module div_sqrt_ctrl (
	input  logic                   Clk_CI,
	input  logic                   Rst_RBI,
	input  logic                   accepted,
	input  logic                   is_sqrt,
	input  logic                   sign_z,
	input  div_sqrt_pkg::op_info_t info_a,
	input  div_sqrt_pkg::op_info_t info_b,
	input  div_sqrt_pkg::exp_t     fmt_bias,
	output logic                   ready,
	output logic                   done,
	output logic                   iter_load,
	output div_sqrt_pkg::result_t  res_meta
);
	import div_sqrt_pkg::*;

	ctrl_state_t           state_q;
	ctrl_state_t           state_d;
	logic [`DSQ_CNT_W-1:0] cnt_q;
	logic                  special;
	logic                  last;
	logic                  div_inval;
	exp_z_t                exp_a;
	exp_z_t                exp_b;
	exp_z_t                bias;
	exp_z_t                exp_unb;
	result_t               meta_d;

	assign special = is_sqrt ? (info_a.zero | info_a.inf | info_a.nan | info_a.sign) :
	                           (info_a.zero | info_a.inf | info_a.nan |
	                            info_b.zero | info_b.inf | info_b.nan);
	assign last = special ? (cnt_q == `DSQ_CNT_W'(1)) : (cnt_q == `DSQ_CNT_W'(`DSQ_ITERS + 1));

	always_comb begin
		state_d = state_q;
		case (state_q)
			ST_IDLE, ST_DONE: state_d = accepted ? ST_ITER : ST_IDLE;
			ST_ITER:          state_d = last ? ST_DONE : ST_ITER;
			default:          state_d = ST_IDLE;
		endcase
	end

	always_ff @(posedge Clk_CI or negedge Rst_RBI) begin
		if (!Rst_RBI) begin
			state_q <= ST_IDLE;
			cnt_q   <= '0;
		end else begin
			state_q <= state_d;
			cnt_q   <= (state_q == ST_ITER) ? cnt_q + 1'b1 : '0;
		end
	end

	assign ready     = (state_q != ST_ITER);
	assign done      = (state_q == ST_DONE);
	assign iter_load = (state_q == ST_ITER) && (cnt_q == '0) && !special;

	assign exp_a     = {info_a.exp[`DSQ_EXP_W-1], info_a.exp}; // Signed, subnormals wrap
	assign exp_b     = {info_b.exp[`DSQ_EXP_W-1], info_b.exp};
	assign bias      = {1'b0, fmt_bias};
	assign exp_unb   = exp_a - bias;
	assign div_inval = (info_a.zero & info_b.zero) | (info_a.inf & info_b.inf);

	always_comb begin
		meta_d      = '0;
		meta_d.sign = sign_z;
		meta_d.cls  = CLS_NORMAL;
		if (is_sqrt) begin
			meta_d.exp = (exp_unb >>> 1) + bias; // Floor of half
			if (info_a.nan) begin
				meta_d.cls     = CLS_QNAN;
				meta_d.invalid = info_a.snan;
			end else if (info_a.zero) begin
				meta_d.cls = CLS_ZERO;
			end else if (info_a.sign) begin
				meta_d.cls     = CLS_QNAN;
				meta_d.invalid = 1'b1;
			end else if (info_a.inf) begin
				meta_d.cls = CLS_INF;
			end
		end else begin
			meta_d.exp = exp_a - exp_b + bias;
			if (info_a.nan | info_b.nan | div_inval) begin
				meta_d.cls     = CLS_QNAN;
				meta_d.invalid = info_a.snan | info_b.snan | div_inval;
			end else if (info_a.inf) begin
				meta_d.cls = CLS_INF;
			end else if (info_b.zero) begin
				meta_d.cls         = CLS_INF;
				meta_d.div_by_zero = 1'b1;
			end else if (info_a.zero | info_b.inf) begin
				meta_d.cls = CLS_ZERO;
			end
		end
	end

	always_ff @(posedge Clk_CI) begin
		if ((state_q == ST_ITER) && last) begin
			res_meta <= meta_d;
		end
	end

	done_pulse: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI) done |=> !done)
		else $error("done held longer than one cycle");

	no_early_done: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
		accepted |=> !done ##2 (done == special))
		else $error("done off its expected edge after an accepted start");

endmodule

// File: source/div_sqrt_top.sv
`timescale 1ns/10ps

module div_sqrt_top (
	input  logic                   Clk_CI,
	input  logic                   Rst_RBI,
	input  logic                   div_start,
	input  logic                   sqrt_start,
	input  div_sqrt_pkg::operand_t op_a,
	input  div_sqrt_pkg::operand_t op_b,
	input  div_sqrt_pkg::fmt_t     fmt,
	output logic                   ready,
	output logic                   done,
	output div_sqrt_pkg::result_t  result
);
	import div_sqrt_pkg::*;

	logic     accepted;
	logic     sign_z;
	logic     is_sqrt;
	logic     exp_odd;
	logic     iter_load;
	op_info_t info_a;
	op_info_t info_b;
	exp_t     fmt_bias;
	result_t  res_meta;
	quot_t    quot;

	preprocess preprocess0 (
		.Clk_CI     (Clk_CI),
		.Rst_RBI    (Rst_RBI),
		.div_start  (div_start),
		.sqrt_start (sqrt_start),
		.ready      (ready),
		.op_a       (op_a),
		.op_b       (op_b),
		.fmt        (fmt),
		.accepted   (accepted),
		.info_a     (info_a),
		.info_b     (info_b),
		.sign_z     (sign_z),
		.is_sqrt    (is_sqrt),
		.exp_odd    (exp_odd),
		.fmt_bias   (fmt_bias)
	);

	div_sqrt_ctrl ctrl0 (
		.Clk_CI    (Clk_CI),
		.Rst_RBI   (Rst_RBI),
		.accepted  (accepted),
		.is_sqrt   (is_sqrt),
		.sign_z    (sign_z),
		.info_a    (info_a),
		.info_b    (info_b),
		.fmt_bias  (fmt_bias),
		.ready     (ready),
		.done      (done),
		.iter_load (iter_load),
		.res_meta  (res_meta)
	);

	iteration_unit iter0 (
		.Clk_CI    (Clk_CI),
		.Rst_RBI   (Rst_RBI),
		.iter_load (iter_load),
		.is_sqrt   (is_sqrt),
		.exp_odd   (exp_odd),
		.mant_a    (info_a.mant),
		.mant_b    (info_b.mant),
		.quot      (quot)
	);

	assign result = '{
		sign:        res_meta.sign,
		cls:         res_meta.cls,
		exp:         res_meta.exp,
		quot:        quot,
		invalid:     res_meta.invalid,
		div_by_zero: res_meta.div_by_zero
	};

endmodule

// File: tb/tb_div_sqrt_model.svh
`ifndef TB_DIV_SQRT_MODEL_SVH
`define TB_DIV_SQRT_MODEL_SVH

function automatic int exp_bits(fmt_t f);
	case (f)
		FMT_FP64: return 11;
		FMT_FP16: return 5;
		default:  return 8; // FP32 and FP16ALT
	endcase
endfunction

function automatic int frac_bits(fmt_t f);
	case (f)
		FMT_FP32: return 23;
		FMT_FP64: return 52;
		FMT_FP16: return 10;
		default:  return 7;
	endcase
endfunction

function automatic int bias_of(fmt_t f);
	return (1 << (exp_bits(f) - 1)) - 1;
endfunction

// IEEE fields with the mantissa normalized to bit 52
function automatic void decode(input fmt_t f, input operand_t op, output logic s,
		output int e, output logic [52:0] m, output logic zero, output logic inf,
		output logic nan, output logic snan);
	int          ew;
	int          mw;
	logic [63:0] frac;
	ew   = exp_bits(f);
	mw   = frac_bits(f);
	s    = op[ew + mw];
	e    = int'((op >> mw) & ((64'd1 << ew) - 1));
	frac = op & ((64'd1 << mw) - 1);
	m    = 53'(frac << (52 - mw));
	zero = (e == 0) && (frac == 0);
	inf  = (e == (1 << ew) - 1) && (frac == 0);
	nan  = (e == (1 << ew) - 1) && (frac != 0);
	snan = nan && !m[51];
	if (e != 0) begin
		m[52] = 1'b1;
	end else begin
		e = 1; // Subnormal scale
		while (!zero && !m[52]) begin
			m = m << 1;
			e = e - 1;
		end
	end
endfunction

function automatic result_t expect_result(logic sq, fmt_t f, operand_t a, operand_t b);
	result_t      r;
	logic         sa, za, ia, na, qa;
	logic         sb, zb, ib, nb, qb;
	int           ea;
	int           eb;
	int           eu;
	int           bias;
	logic [52:0]  ma;
	logic [52:0]  mb;
	logic [107:0] num;
	logic [111:0] rad;
	logic [111:0] cand;
	logic [54:0]  root;
	r    = '0;
	bias = bias_of(f);
	decode(f, a, sa, ea, ma, za, ia, na, qa);
	decode(f, b, sb, eb, mb, zb, ib, nb, qb);
	if (!sq) begin
		r.sign = sa ^ sb;
		r.exp  = exp_z_t'(ea - eb + bias);
		num    = 108'(ma) << 54;
		r.quot = quot_t'(num / 108'(mb));
		if (na || nb || (za && zb) || (ia && ib)) begin
			r.cls     = CLS_QNAN;
			r.invalid = qa || qb || (za && zb) || (ia && ib);
		end else if (ia) begin
			r.cls = CLS_INF;
		end else if (zb) begin
			r.cls         = CLS_INF;
			r.div_by_zero = 1'b1;
		end else if (za || ib) begin
			r.cls = CLS_ZERO;
		end
	end else begin
		r.sign = sa;
		eu     = ea - bias;
		r.exp  = exp_z_t'((eu >>> 1) + bias); // Floor of half
		rad    = 112'(ma) << (56 + (eu & 1));
		root   = '0;
		for (int i = 54; i >= 0; i--) begin
			cand = 112'(root | (55'd1 << i));
			if (cand * cand <= rad) root = root | (55'd1 << i);
		end
		r.quot = root;
		if (na) begin
			r.cls     = CLS_QNAN;
			r.invalid = qa;
		end else if (za) begin
			r.cls = CLS_ZERO;
		end else if (sa) begin
			r.cls     = CLS_QNAN;
			r.invalid = 1'b1;
		end else if (ia) begin
			r.cls = CLS_INF;
		end
	end
	return r;
endfunction

`endif

// File: tb/tb_div_sqrt.sv
`timescale 1ns/10ps
`include "div_sqrt_defs.svh"

module tb_div_sqrt;
	import div_sqrt_pkg::*;

	`include "tb_div_sqrt_model.svh"

	localparam int NUM_TESTS   = 33;
	localparam int MAX_CYCLES  = NUM_TESTS * (`DSQ_ITERS + 4) + 50;
	localparam int LAT_NORMAL  = `DSQ_ITERS + 2;
	localparam int LAT_SPECIAL = 2;
	localparam logic [51:0] QNAN_FRAC = 52'h8_0000_0000_0000;
	localparam logic [51:0] SNAN_FRAC = 52'h4_0000_0000_0000;

	logic     Clk_CI;
	logic     Rst_RBI;
	logic     div_start;
	logic     sqrt_start;
	operand_t op_a;
	operand_t op_b;
	fmt_t     fmt;
	logic     ready;
	logic     done;
	result_t  result;

	result_t  want_res;
	int       want_lat;
	string    test_name;
	int       lat;
	logic     busy;
	int       cycles = 0;
	int       errors;
	int       passed;
	int       failed;
	integer   seed;

	div_sqrt_top dut0 (
		.Clk_CI     (Clk_CI),
		.Rst_RBI    (Rst_RBI),
		.div_start  (div_start),
		.sqrt_start (sqrt_start),
		.op_a       (op_a),
		.op_b       (op_b),
		.fmt        (fmt),
		.ready      (ready),
		.done       (done),
		.result     (result)
	);

	always #50 Clk_CI = ~Clk_CI;

	// Edges since the last accepted start
	always_ff @(posedge Clk_CI or negedge Rst_RBI) begin
		if (!Rst_RBI) begin
			busy <= 1'b0;
			lat  <= 0;
		end else if ((div_start || sqrt_start) && (!busy || done)) begin
			busy <= 1'b1;
			lat  <= 0;
		end else if (done) begin
			busy <= 1'b0;
		end else if (busy) begin
			lat <= lat + 1;
		end
	end

	always @(posedge Clk_CI) begin
		cycles = cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout: no end of the tests after %0d cycles", cycles);
			$display("Verification failed");
			$finish;
		end
	end

	function automatic logic result_ok(result_t act, result_t want);
		if (act.cls != want.cls || act.invalid != want.invalid) return 1'b0;
		if (act.div_by_zero != want.div_by_zero) return 1'b0;
		if (want.cls != CLS_QNAN && act.sign != want.sign) return 1'b0; // NaN sign is free
		if (want.cls == CLS_NORMAL && (act.exp != want.exp || act.quot != want.quot)) return 1'b0;
		return 1'b1;
	endfunction

	check_result: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
		done |-> result_ok(result, want_res))
		else begin
			$display("[ERROR] %s: expected %h actual %h", test_name, want_res, result);
			errors = errors + 1;
		end

	check_latency: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
		done |-> (lat == want_lat))
		else begin
			$display("[ERROR] %s latency: expected %0d actual %0d", test_name, want_lat, lat);
			errors = errors + 1;
		end

	// Idle, or in the done cycle of the running operation
	check_ready: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
		ready == (!busy || done))
		else begin
			$display("[ERROR] %s ready: expected %0b actual %0b", test_name,
			         !$sampled(busy) || $sampled(done), $sampled(ready));
			errors = errors + 1;
		end

	check_single_done: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI) done |-> busy)
		else begin
			$display("%s: done pulsed with no operation running", test_name);
			errors = errors + 1;
		end

	function automatic logic [51:0] pick_frac();
		return 52'({$random(seed), $random(seed)});
	endfunction

	// Normal biased exponent with the given lsb
	function automatic int pick_exp(fmt_t f, int par);
		int span;
		span = ((1 << exp_bits(f)) - 3) / 2;
		return 2 + 2 * int'(($random(seed) & 32'h7fff_ffff) % span) + par;
	endfunction

	function automatic operand_t pack_op(fmt_t f, logic s, int e, logic [51:0] frac);
		int       ew;
		int       mw;
		operand_t box;
		ew  = exp_bits(f);
		mw  = frac_bits(f);
		box = {`DSQ_OP_W{1'b1}} << (ew + mw + 1); // NaN boxing
		return box | (operand_t'(s) << (ew + mw)) | (operand_t'(e) << mw) |
		       operand_t'(frac >> (52 - mw));
	endfunction

	function automatic operand_t normal_op(fmt_t f, logic s, int par);
		return pack_op(f, s, pick_exp(f, par), pick_frac());
	endfunction

	// Caller sits on a falling edge
	task automatic run_op(input string name, input logic sq, input fmt_t f,
			input operand_t a, input operand_t b, input logic poke);
		int errs_before;
		int wait_n;
		errs_before = errors;
		test_name   = name;
		want_res    = expect_result(sq, f, a, b);
		want_lat    = (want_res.cls == CLS_NORMAL) ? LAT_NORMAL : LAT_SPECIAL;
		op_a        = a;
		op_b        = b;
		fmt         = f;
		div_start   = !sq;
		sqrt_start  = sq;
		@(negedge Clk_CI);
		div_start  = 1'b0;
		sqrt_start = 1'b0;
		wait_n     = 0;
		while (!done) begin
			if (poke && wait_n == 3) begin
				div_start = 1'b1; // Must be ignored while busy
				op_a      = ~a;
			end else begin
				div_start = 1'b0;
				op_a      = a;
			end
			@(negedge Clk_CI);
			wait_n++;
		end
		div_start = 1'b0;
		@(negedge Clk_CI);
		if (poke) repeat (4) @(negedge Clk_CI);
		if (errors == errs_before) begin
			passed++;
			$display("%s: ok", name);
		end else begin
			failed++;
			$display("%s: FAILED", name);
		end
	endtask

	initial begin
		operand_t sub32;
		operand_t subalt;
		Clk_CI     = 1'b0;
		Rst_RBI    = 1'b0;
		div_start  = 1'b0;
		sqrt_start = 1'b0;
		op_a       = '0;
		op_b       = '0;
		fmt        = FMT_FP64;
		want_res   = '0;
		want_lat   = 0;
		test_name  = "reset";
		errors     = 0;
		passed     = 0;
		failed     = 0;
		seed       = 73135;
		repeat (4) @(negedge Clk_CI);
		Rst_RBI = 1'b1;

		for (int i = 0; i < 4; i++) begin
			run_op("div_fp64", 1'b0, FMT_FP64, normal_op(FMT_FP64, i[0], i[1]),
			       normal_op(FMT_FP64, i[1], i[0]), 1'b0);
			run_op("div_fp32", 1'b0, FMT_FP32, normal_op(FMT_FP32, i[1], i[0]),
			       normal_op(FMT_FP32, i[0], 0), 1'b0);
		end
		for (int i = 0; i < 4; i++) begin
			run_op("sqrt_fp64", 1'b1, FMT_FP64, normal_op(FMT_FP64, 1'b0, i[0]), '0, 1'b0);
			run_op("sqrt_fp16", 1'b1, FMT_FP16, normal_op(FMT_FP16, 1'b0, i[0]), '0, 1'b0);
		end

		sub32  = pack_op(FMT_FP32, 1'b0, 0, pick_frac() | (52'd1 << 29));
		subalt = pack_op(FMT_FP16ALT, 1'b0, 0, 52'd1 << 45); // Deepest shift
		run_op("div_sub_fp32", 1'b0, FMT_FP32, sub32, normal_op(FMT_FP32, 1'b1, 0), 1'b0);
		run_op("div_fp32_by_sub", 1'b0, FMT_FP32, normal_op(FMT_FP32, 1'b0, 1), sub32, 1'b0);
		run_op("sqrt_sub_fp32", 1'b1, FMT_FP32, sub32, '0, 1'b0);
		run_op("div_sub_fp16alt", 1'b0, FMT_FP16ALT, subalt,
		       normal_op(FMT_FP16ALT, 1'b0, 1), 1'b0);
		run_op("div_fp16alt_by_sub", 1'b0, FMT_FP16ALT, normal_op(FMT_FP16ALT, 1'b1, 0),
		       pack_op(FMT_FP16ALT, 1'b0, 0, pick_frac() | (52'd1 << 45)), 1'b0);
		run_op("sqrt_sub_fp16alt", 1'b1, FMT_FP16ALT, subalt, '0, 1'b0);

		run_op("div_zero_by_zero", 1'b0, FMT_FP64, pack_op(FMT_FP64, 1'b0, 0, '0),
		       pack_op(FMT_FP64, 1'b1, 0, '0), 1'b0);
		run_op("div_inf_by_inf", 1'b0, FMT_FP16, pack_op(FMT_FP16, 1'b1, 31, '0),
		       pack_op(FMT_FP16, 1'b0, 31, '0), 1'b0);
		run_op("div_by_zero", 1'b0, FMT_FP64, normal_op(FMT_FP64, 1'b1, 0),
		       pack_op(FMT_FP64, 1'b0, 0, '0), 1'b0);
		run_op("div_zero_by_x", 1'b0, FMT_FP32, pack_op(FMT_FP32, 1'b1, 0, '0),
		       normal_op(FMT_FP32, 1'b0, 1), 1'b0);
		run_op("div_x_by_inf", 1'b0, FMT_FP64, normal_op(FMT_FP64, 1'b0, 1),
		       pack_op(FMT_FP64, 1'b1, 2047, '0), 1'b0);
		run_op("div_snan", 1'b0, FMT_FP32, pack_op(FMT_FP32, 1'b0, 255, SNAN_FRAC),
		       normal_op(FMT_FP32, 1'b0, 0), 1'b0);

		run_op("sqrt_negative", 1'b1, FMT_FP64, normal_op(FMT_FP64, 1'b1, 1), '0, 1'b0);
		run_op("sqrt_neg_zero", 1'b1, FMT_FP64, pack_op(FMT_FP64, 1'b1, 0, '0), '0, 1'b0);
		run_op("sqrt_pos_inf", 1'b1, FMT_FP32, pack_op(FMT_FP32, 1'b0, 255, '0), '0, 1'b0);
		run_op("sqrt_qnan", 1'b1, FMT_FP16ALT, pack_op(FMT_FP16ALT, 1'b0, 255, QNAN_FRAC),
		       '0, 1'b0);

		run_op("div_busy_start", 1'b0, FMT_FP64, normal_op(FMT_FP64, 1'b0, 0),
		       normal_op(FMT_FP64, 1'b1, 1), 1'b1);

		$display("Tests: %0d passed, %0d failed, %0d errors", passed, failed, errors);
		if (failed == 0 && errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

// File: project.f
+incdir+source
+incdir+tb
source/div_sqrt_pkg.sv
source/lzc.sv
source/preprocess.sv
source/iteration_unit.sv
source/div_sqrt_ctrl.sv
source/div_sqrt_top.sv
tb/tb_div_sqrt.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_div_sqrt
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS    := $(wildcard source/*.sv source/*.svh tb/*.sv tb/*.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Verification failed" $(LOG) || \
	   ! grep -q "Verification passed" $(LOG); then \
		echo "Simulation run reported a failure"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
